// ==== rp_analog_io.f ====
rtl/rp_analog_pkg.sv
rtl/rp_adc_frontend.sv
rtl/rp_dac_mixer.sv
rtl/rp_moving_avg.sv
rtl/rp_dac_output.sv
rtl/rp_analog_top.sv
dv/tb_clk_gen.sv
dv/tb_rp_analog.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rp_analog_io simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rp_analog_io.f \
  --top-module tb_rp_analog \
  -o sim_rp_analog

./obj_dir/sim_rp_analog | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

// ==== dv/tb_rp_analog.sv ====
// Testbench for the analog datapath top level
//   Random stimulus from a fixed seed, driven on the falling edge
//   Reference model for ADC conversion, saturation, DAC code and window mean
//   Per-test reporting, summary line and watchdog

`default_nettype none
`timescale 1ns/1ns

module tb_rp_analog
  import rp_analog_pkg::*;
();

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD = 20;
  localparam int WIN        = 2**AVG_LOG2_DEF;  // DAC B window length
  localparam int N_AVG      = 300;
  localparam int N_ADC      = 200;
  localparam int N_SAT      = 200;
  localparam int N_LOOP     = 100;
  localparam int N_RESUME   = 50;   // Loop off again
  localparam int TOTAL_CYC  = 5 + 1 + N_AVG + N_ADC + N_SAT + N_LOOP + N_RESUME + 8;
  localparam int WATCHDOG_NS = (TOTAL_CYC + 100) * CLK_PERIOD;  // 100 cycles spare

  localparam sample_t SMP_MAX = sample_t'(2**(SMP_W-1) - 1);   // +8191
  localparam sample_t SMP_MIN = sample_t'(-(2**(SMP_W-1)));    // -8192
  localparam logic [SMP_W-1:0] MAG_MASK = {1'b0, {(SMP_W-1){1'b1}}};

  ////////////////////////////////////////////////////////////////////////////
  // DUT and clocking
  ////////////////////////////////////////////////////////////////////////////

  logic      adc_clk;
  logic      adc_rstn;
  adc_raw_t  adc_a_raw;
  adc_raw_t  adc_b_raw;
  logic      digital_loop;
  sample_t   asg_a;
  sample_t   asg_b;
  sample_t   pid_a;
  sample_t   pid_b;
  sample_t   adc_a_smp;
  sample_t   adc_b_smp;
  dac_code_t dac_a_code;
  dac_code_t dac_b_code;

  integer seed = 32'haa15;
  int     test_errors = 0;
  int     test_checks = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  tb_clk_gen u_clk_gen (
    .adc_clk_o  (adc_clk),
    .adc_rstn_o (adc_rstn)
  );

  rp_analog_top u_dut (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_a_i        (adc_a_raw),
    .adc_b_i        (adc_b_raw),
    .digital_loop_i (digital_loop),
    .asg_a_i        (asg_a),
    .asg_b_i        (asg_b),
    .pid_a_i        (pid_a),
    .pid_b_i        (pid_b),
    .adc_a_o        (adc_a_smp),
    .adc_b_o        (adc_b_smp),
    .dac_a_o        (dac_a_code),
    .dac_b_o        (dac_b_code)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  adc_raw_t  cap_raw_a;    // Raw words seen at the last edge
  adc_raw_t  cap_raw_b;
  dac_code_t exp_dac_a;
  dac_code_t exp_dac_b;
  dac_code_t window[$];    // Oldest code at the front

  // Upper 14 bits with the MSB kept and the rest inverted
  function automatic sample_t rule_a(input adc_raw_t raw);
    logic [SMP_W-1:0] top;
    top = raw[ADC_IN_W-1 -: SMP_W];
    return sample_t'(top ^ MAG_MASK);
  endfunction

  // Integer sum clamped to the 14-bit range
  function automatic sample_t rule_s(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > int'(SMP_MAX)) s = int'(SMP_MAX);
    else if (s < int'(SMP_MIN)) s = int'(SMP_MIN);
    return sample_t'(s);
  endfunction

  function automatic dac_code_t rule_d(input sample_t smp);
    return dac_code_t'(smp ^ MAG_MASK);  // Negative slope offset
  endfunction

  // Floor of the mean over the window
  function automatic dac_code_t window_mean();
    int sum;
    sum = 0;
    foreach (window[i]) sum += int'(window[i]);
    return dac_code_t'(sum / WIN);
  endfunction

  // Inputs only move on the falling edge
  always @(posedge adc_clk) begin
    if (!adc_rstn) begin
      cap_raw_a = '0;
      cap_raw_b = '0;
      exp_dac_a = '0;
      exp_dac_b = '0;
      window.delete();
      for (int i = 0; i < WIN; i++) window.push_back('0);
    end else begin
      cap_raw_a = adc_a_raw;
      cap_raw_b = adc_b_raw;
      exp_dac_a = rule_d(rule_s(asg_a, pid_a));
      exp_dac_b = window_mean();         // Codes of the previous 64 edges
      void'(window.pop_front());
      window.push_back(exp_dac_a);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [SMP_W-1:0] actual,
                             input logic [SMP_W-1:0] expected);
    test_checks++;
    assert (actual === expected) else begin
      $display("ERROR: %s expected 0x%h, got 0x%h at %0t ns", name, expected, actual, $time);
      test_errors++;
    end
  endtask

  task automatic check_outputs();
    sample_t exp_adc_a;
    sample_t exp_adc_b;
    if (digital_loop) begin
      exp_adc_a = rule_s(asg_a, pid_a);  // Same-cycle loop path
      exp_adc_b = rule_s(asg_b, pid_b);
    end else begin
      exp_adc_a = rule_a(cap_raw_a);
      exp_adc_b = rule_a(cap_raw_b);
    end
    check_value("adc_a_o", adc_a_smp, exp_adc_a);
    check_value("adc_b_o", adc_b_smp, exp_adc_b);
    check_value("dac_a_o", dac_a_code, exp_dac_a);
    check_value("dac_b_o", dac_b_code, exp_dac_b);
  endtask

  // Random sample, or full scale in half the draws
  task automatic pick_sample(input logic full_scale, output sample_t smp);
    int sel;
    sel = $random(seed) & 7;
    if (full_scale && sel < 2) smp = SMP_MAX;
    else if (full_scale && sel < 4) smp = SMP_MIN;
    else smp = sample_t'($random(seed));
  endtask

  task automatic run_cycle(input logic loop, input logic full_scale);
    @(negedge adc_clk);
    digital_loop = loop;
    adc_a_raw    = adc_raw_t'($random(seed));
    adc_b_raw    = adc_raw_t'($random(seed));
    pick_sample(full_scale, asg_a);
    pick_sample(full_scale, asg_b);
    pick_sample(full_scale, pid_a);
    pick_sample(full_scale, pid_b);
    @(posedge adc_clk);
    #2;                                  // Outputs settled past the edge
    check_outputs();
  endtask

  task automatic start_test();
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("[PASS] %s, %0d checks", name, test_checks);
    end else begin
      tests_failed++;
      $display("[FAIL] %s, %0d of %0d checks wrong", name, test_errors, test_checks);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    // Nonzero everywhere while reset is held
    digital_loop = 1'b1;
    adc_a_raw    = 16'ha5c3;
    adc_b_raw    = 16'h3c5a;
    asg_a        = sample_t'(14'h1234);
    asg_b        = sample_t'(14'h2bcd);
    pid_a        = sample_t'(14'h0f0f);
    pid_b        = sample_t'(14'h3001);

    @(posedge adc_rstn);
    #1;
    start_test();
    check_value("dac_a_o", dac_a_code, '0);
    check_value("dac_b_o", dac_b_code, '0);
    finish_test("reset");

    // Right after reset, so the window starts out as zeros
    start_test();
    @(posedge adc_clk);                  // First edge out of reset
    #2;
    check_outputs();
    repeat (N_AVG) run_cycle(1'b0, 1'b0);
    finish_test("moving_average");

    start_test();
    repeat (N_ADC) run_cycle(1'b0, 1'b0);
    finish_test("adc_conversion");

    start_test();
    repeat (N_SAT) run_cycle(1'b0, 1'b1);
    finish_test("saturation");

    start_test();
    repeat (N_LOOP) run_cycle(1'b1, 1'b1);
    repeat (N_RESUME) run_cycle(1'b0, 1'b0);  // ADC path back
    finish_test("digital_loop");

    $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule : tb_rp_analog

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset
//   20 ns adc_clk
//   Active-low reset held for 5 cycles, released on a falling edge

`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
  output logic adc_clk_o,   // Free-running ADC clock
  output logic adc_rstn_o   // Sync reset, active low
);

  localparam int HALF_PERIOD = 10;  // 20 ns period
  localparam int RST_CYCLES  = 5;

  initial begin
    adc_clk_o = 1'b0;
    forever #HALF_PERIOD adc_clk_o = ~adc_clk_o;
  end

  // Release away from the rising edge
  initial begin
    adc_rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk_o);
    @(negedge adc_clk_o);
    adc_rstn_o = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== rtl/rp_analog_top.sv ====
// Analog datapath top level
//   ADC front end with digital-loop select
//   Generator and controller mixer with saturation
//   DAC output stage with moving average on channel B

`default_nettype none
`timescale 1ns/1ns

module rp_analog_top
  import rp_analog_pkg::*;
#(
  parameter int AVG_LOG2 = AVG_LOG2_DEF  // DAC B window, log2
) (
  // Clock and reset
  input  logic      adc_clk,         // ADC clock
  input  logic      adc_rstn,        // Sync reset, active low
  // ADC pins
  input  adc_raw_t  adc_a_i,         // Raw ADC channel A
  input  adc_raw_t  adc_b_i,         // Raw ADC channel B
  // Configuration
  input  logic      digital_loop_i,  // Feed DAC samples to ADC stream
  // Generator and controller streams
  input  sample_t   asg_a_i,         // Generator A
  input  sample_t   asg_b_i,         // Generator B
  input  sample_t   pid_a_i,         // Controller A
  input  sample_t   pid_b_i,         // Controller B
  // ADC sample streams
  output sample_t   adc_a_o,         // To scope and controller
  output sample_t   adc_b_o,
  // DAC codes
  output dac_code_t dac_a_o,         // DAC channel A
  output dac_code_t dac_b_o          // DAC channel B, averaged A
);

  ////////////////////////////////////////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////////////////////////////////////////

  sample_t mix_a;  // Saturated sum A
  sample_t mix_b;  // Saturated sum B, loop only

  ////////////////////////////////////////////////////////////////////////////
  // ADC front end
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_frontend u_frontend (
    .adc_clk        (adc_clk),
    .adc_rstn       (adc_rstn),
    .adc_a_i        (adc_a_i),
    .adc_b_i        (adc_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (mix_a),   // Loop takes the mixer sums
    .loop_b_i       (mix_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Mixer
  ////////////////////////////////////////////////////////////////////////////

  // Combinational, no register between mixer and loop
  rp_dac_mixer u_mixer (
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .dac_a_o (mix_a),
    .dac_b_o (mix_b)
  );

  ////////////////////////////////////////////////////////////////////////////
  // DAC output
  ////////////////////////////////////////////////////////////////////////////

  // Only mixer A reaches the DAC pins
  rp_dac_output #(
    .AVG_LOG2 (AVG_LOG2)
  ) u_dac_out (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .dac_a_i  (mix_a),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

endmodule : rp_analog_top

`default_nettype wire

// ==== rtl/rp_dac_output.sv ====
// DAC output stage
//   Signed sample to negative-slope offset code
//   Output register for DAC channel A
//   Moving average of channel A driving DAC channel B

`default_nettype none
`timescale 1ns/1ns

module rp_dac_output
  import rp_analog_pkg::*;
#(
  parameter int AVG_LOG2 = AVG_LOG2_DEF  // Averaging window, log2
) (
  input  logic      adc_clk,   // ADC clock
  input  logic      adc_rstn,  // Sync reset, active low
  input  sample_t   dac_a_i,   // Saturated mixer sum A
  output dac_code_t dac_a_o,   // DAC channel A code
  output dac_code_t dac_b_o    // DAC channel B, averaged A
);

  dac_code_t code_a;  // Unregistered channel A code

  ////////////////////////////////////////////////////////////////////////////
  // Channel A
  ////////////////////////////////////////////////////////////////////////////

  // Sign kept, magnitude bits inverted for the negative slope
  assign code_a = {dac_a_i[SMP_W-1], ~dac_a_i[SMP_W-2:0]};

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= '0;
    end else begin
      dac_a_o <= code_a;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel B
  ////////////////////////////////////////////////////////////////////////////

  // Same code as A, smoothed over the window
  rp_moving_avg #(
    .AVG_LOG2 (AVG_LOG2)
  ) u_moving_avg (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .code_i   (code_a),
    .avg_o    (dac_b_o)  // Registered inside the averager
  );

endmodule : rp_dac_output

`default_nettype wire

// ==== rtl/rp_moving_avg.sv ====
// Moving average for DAC channel B
//   Ring buffer of the last 2**AVG_LOG2 codes
//   Wrapping write index
//   Running sum and registered scaled output

`default_nettype none
`timescale 1ns/1ns

module rp_moving_avg
  import rp_analog_pkg::*;
#(
  parameter int AVG_LOG2 = AVG_LOG2_DEF  // Window is 2**AVG_LOG2 codes
) (
  input  logic      adc_clk,   // ADC clock
  input  logic      adc_rstn,  // Sync reset, active low
  input  dac_code_t code_i,    // New code every cycle
  output dac_code_t avg_o      // Window mean
);

  localparam int DEPTH = 2**AVG_LOG2;
  localparam int SUM_W = SMP_W + AVG_LOG2;  // Full window fits without wrap

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  dac_code_t           ring_q [DEPTH];  // Window history
  logic [AVG_LOG2-1:0] wr_idx_q;        // Slot of the oldest code
  logic [SUM_W-1:0]    sum_q;           // Sum over the window
  logic [SUM_W-1:0]    sum_nxt;
  dac_code_t           oldest;

  // Entry about to be overwritten leaves the window
  assign oldest = ring_q[wr_idx_q];

  // New code in, oldest out
  assign sum_nxt = sum_q + SUM_W'(code_i) - SUM_W'(oldest);

  ////////////////////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      // Empty window counts as zeros
      for (int i = 0; i < DEPTH; i++) begin
        ring_q[i] <= '0;
      end
      wr_idx_q <= '0;
      sum_q    <= '0;
      avg_o    <= '0;
    end else begin
      ring_q[wr_idx_q] <= code_i;          // Replace oldest
      wr_idx_q         <= wr_idx_q + 1'b1;  // Wraps at DEPTH
      sum_q            <= sum_nxt;
      // Previous sum divided by the window size
      avg_o            <= sum_q[SUM_W-1:AVG_LOG2];
    end
  end

endmodule : rp_moving_avg

`default_nettype wire

// ==== rtl/rp_dac_mixer.sv ====
// DAC mixer
//   Generator plus controller sum per channel
//   Saturation of the 15-bit sum back to 14 bits

`default_nettype none
`timescale 1ns/1ns

module rp_dac_mixer
  import rp_analog_pkg::*;
(
  input  sample_t asg_a_i,  // Generator channel A
  input  sample_t asg_b_i,  // Generator channel B
  input  sample_t pid_a_i,  // Controller channel A
  input  sample_t pid_b_i,  // Controller channel B
  output sample_t dac_a_o,  // Saturated sum A
  output sample_t dac_b_o   // Saturated sum B
);

  // One extra bit so the sum never wraps
  logic signed [SMP_W:0] sum_a;
  logic signed [SMP_W:0] sum_b;

  // Clamp when the top two bits disagree
  function automatic sample_t sat_sum(input logic signed [SMP_W:0] sum);
    sample_t res;
    if (sum[SMP_W] ^ sum[SMP_W-1]) begin
      // Overflow, sign bit tells the direction
      res = sample_t'({sum[SMP_W], {(SMP_W-1){~sum[SMP_W]}}});
    end else begin
      res = sample_t'(sum[SMP_W-1:0]);
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sums
  ////////////////////////////////////////////////////////////////////////////

  // Operands sign extended to the sum width
  assign sum_a = (SMP_W+1)'(asg_a_i) + (SMP_W+1)'(pid_a_i);
  assign sum_b = (SMP_W+1)'(asg_b_i) + (SMP_W+1)'(pid_b_i);

  ////////////////////////////////////////////////////////////////////////////
  // Saturation
  ////////////////////////////////////////////////////////////////////////////

  assign dac_a_o = sat_sum(sum_a);  // Range -8192 .. 8191
  assign dac_b_o = sat_sum(sum_b);

endmodule : rp_dac_mixer

`default_nettype wire

// ==== rtl/rp_adc_frontend.sv ====
// ADC front end
//   Capture registers for both raw ADC words
//   Negative-slope offset code to two's complement conversion
//   Digital-loop select between ADC and mixer samples

`default_nettype none
`timescale 1ns/1ns

module rp_adc_frontend
  import rp_analog_pkg::*;
(
  input  logic     adc_clk,         // ADC clock
  input  logic     adc_rstn,        // Sync reset, active low
  input  adc_raw_t adc_a_i,         // Raw ADC channel A
  input  adc_raw_t adc_b_i,         // Raw ADC channel B
  input  logic     digital_loop_i,  // Loop DAC samples back
  input  sample_t  loop_a_i,        // Mixer sum A
  input  sample_t  loop_b_i,        // Mixer sum B
  output sample_t  adc_a_o,         // Sample stream A
  output sample_t  adc_b_o          // Sample stream B
);

  // Upper bits of each raw word only
  logic [SMP_W-1:0] raw_a_q;
  logic [SMP_W-1:0] raw_b_q;
  sample_t          smp_a;
  sample_t          smp_b;

  // Offset code to signed, MSB kept and the rest inverted
  function automatic sample_t adc_to_smp(input logic [SMP_W-1:0] raw);
    return sample_t'({raw[SMP_W-1], ~raw[SMP_W-2:0]});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_a_i[ADC_IN_W-1:ADC_IN_W-SMP_W];  // Drop reserved LSBs
      raw_b_q <= adc_b_i[ADC_IN_W-1:ADC_IN_W-SMP_W];
    end
  end

  assign smp_a = adc_to_smp(raw_a_q);
  assign smp_b = adc_to_smp(raw_b_q);

  ////////////////////////////////////////////////////////////////////////////
  // Loop select
  ////////////////////////////////////////////////////////////////////////////

  // Loop path bypasses the capture stage
  assign adc_a_o = digital_loop_i ? loop_a_i : smp_a;
  assign adc_b_o = digital_loop_i ? loop_b_i : smp_b;

endmodule : rp_adc_frontend

`default_nettype wire

// ==== rtl/rp_analog_pkg.sv ====
// Shared definitions for the analog datapath
//   Sample and DAC code widths
//   Raw ADC word, internal sample and DAC code types
//   Default averaging window for DAC channel B

`default_nettype none

package rp_analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Converter delivers 16 bits, the two LSBs are reserved
  localparam int ADC_IN_W = 16;

  // Processed sample and DAC code width
  localparam int SMP_W = 14;

  ////////////////////////////////////////////////////////////////////////////
  // Averaging
  ////////////////////////////////////////////////////////////////////////////

  localparam int AVG_LOG2_DEF = 6;  // 64 sample window

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Raw word straight from the ADC pins
  typedef logic [ADC_IN_W-1:0] adc_raw_t;

  // Two's complement stream sample
  typedef logic signed [SMP_W-1:0] sample_t;

  // Negative-slope offset code for the DAC
  typedef logic [SMP_W-1:0] dac_code_t;

endpackage : rp_analog_pkg

`default_nettype wire
